// ==== build.f ====
+incdir+.
cft_ctl_pkg.sv
cft_bus_pkg.sv
int_if.sv
int_fsm.sv
micro_seq.sv
cft_int_top.sv
cft_int_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cft_int_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the exit code of the model
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cft_int_checks.svh ====
// Compare tasks for the interrupt testbench; needs errors and checks counters declared before it
`ifndef CFT_INT_CHECKS_SVH
`define CFT_INT_CHECKS_SVH

////////////////////////////////////////
// Result compares
////////////////////////////////////////

// Interrupt flag against the reference model
task automatic check_flag(input string tag, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, fi is %b, expected %b", $time, tag, got, exp);
   end
endtask

// Acknowledge, request and fetch levels
task automatic check_ack(input string tag, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, tag, got, exp);
   end
endtask

// Index strobe in EXEC, high only for IDX
task automatic check_idx(input string tag, input logic got, input opcode_t op);
   logic exp;
   exp = (op == IDX);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, idx_strobe %b for %s", $time, tag, got, op.name());
   end
endtask

// Event totals over one test
task automatic check_count(input string tag, input int got, input int exp);
   checks++;
   if (got != exp) begin
      errors++;
      $display("error at %0t: %s, counted %0d, expected %0d", $time, tag, got, exp);
   end
endtask

`endif

// ==== cft_int_tb.sv ====
// Testbench for the interrupt path; irq only moves between instructions, fixed random seed
`timescale 1ns/1ps
`include "cft_consts.svh"

module cft_int_tb;

   import cft_ctl_pkg::*;
   import cft_bus_pkg::*;

   localparam int N_RAND = 40;
   localparam int N_MASK = 20;
   localparam int N_WAIT = 8;
   localparam int N_IDX  = 30;
   // Fetch, exec and a possible entry step per instruction, plus setup and slack
   localparam int MAX_CYCLES = (N_RAND + N_MASK + N_WAIT + N_IDX + 10) * 3
                               + `CFT_SYNC_STAGES + 20;

   logic    clk4;
   logic    rst;
   logic    irq;
   opcode_t opcode;
   word_t   ibus;
   logic    instr_take;
   logic    fi;
   logic    irqs;
   logic    irq_ack;
   logic    idx_strobe;

   int      errors = 0;
   int      checks = 0;
   int      cycles = 0;
   int      tests = 0;
   int      failed = 0;
   int      ack_count = 0;
   int      strobe_count = 0;
   // Model state of the compare process
   logic    model_fi = 1'b0;
   opcode_t exec_op = NOP;
   logic    in_exec = 1'b0;
   logic    flag_due = 1'b0;
   logic    entry_due = 1'b0;
   logic    no_ack = 1'b0;

   `include "cft_int_checks.svh"

   initial begin
      clk4 = 1'b0;
      forever #2 clk4 = ~clk4;
   end

   cft_int_top DUT (
      .clk4 (clk4), .rst (rst), .opcode (opcode), .ibus (ibus), .irq (irq),
      .instr_take (instr_take), .fi (fi), .irqs (irqs),
      .irq_ack (irq_ack), .idx_strobe (idx_strobe)
   );

   ////////////////////////////////////////
   // Reference model and helpers
   ////////////////////////////////////////

   // Next fi after one instruction
   function automatic logic ref_next_fi(input logic cur, input opcode_t op, input word_t data);
      case (op)
         STI:     return 1'b1;
         CLI:     return 1'b0;
         LDF:     return data[`CFT_FLAG_BIT];
         default: return cur;
      endcase
   endfunction

   function automatic opcode_t pick_op(input int sel);
      case (sel)
         0:       return STI;
         1:       return CLI;
         2:       return LDF;
         default: return NOP;
      endcase
   endfunction

   // Entered and left at 1 ns after a rising edge, ends after the EXEC edge
   task automatic do_instr(input opcode_t op, input word_t data);
      opcode = op;
      ibus   = data;
      @(negedge clk4);
      while (!instr_take) @(negedge clk4);
      @(posedge clk4);
      @(posedge clk4);
      #1;
   endtask

   task automatic report_test(input string name, input int err0);
      tests++;
      if (errors == err0) begin
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   ////////////////////////////////////////
   // Compare process, samples mid-cycle
   ////////////////////////////////////////

   always @(negedge clk4) begin
      if (rst) begin
         model_fi = 1'b0;
         in_exec  = 1'b0;
         flag_due = 1'b0;
      end else begin
         if (flag_due) check_flag("after step", fi, model_fi);
         if (entry_due) check_ack("irqs after entry", irqs, 1'b0);
         flag_due  = 1'b0;
         entry_due = 1'b0;
         if (no_ack) check_ack("irq_ack while masked", irq_ack, 1'b0);
         if (idx_strobe) strobe_count++;
         if (in_exec) begin
            // EXEC follows the fetch step and never fetches
            check_ack("instr_take in exec", instr_take, 1'b0);
            check_idx("exec", idx_strobe, exec_op);
            model_fi = ref_next_fi(model_fi, exec_op, ibus);
            in_exec  = 1'b0;
            flag_due = 1'b1;
         end else if (instr_take) begin
            exec_op = opcode;
            in_exec = 1'b1;
         end else if (irq_ack) begin
            // Interrupt entry issues CLI
            ack_count++;
            model_fi  = 1'b0;
            flag_due  = 1'b1;
            entry_due = 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      int      err0;
      int      ack0;
      int      strobe0;
      int      idx_sent;
      int      tries;
      opcode_t op;
      rst    = 1'b1;
      irq    = 1'b0;
      opcode = NOP;
      ibus   = '0;
      void'($urandom(32'h2ac01886));
      repeat (2) @(posedge clk4);
      #1 rst = 1'b0;

      // Quiet outputs and a first fetch
      err0 = errors;
      @(negedge clk4);
      check_flag("after reset", fi, 1'b0);
      check_ack("irqs after reset", irqs, 1'b0);
      check_ack("irq_ack after reset", irq_ack, 1'b0);
      // First cycle out of reset is a fetch
      check_ack("instr_take after reset", instr_take, 1'b1);
      while (!instr_take) @(negedge clk4);
      @(posedge clk4);
      #1;
      report_test("reset", err0);

      err0   = errors;
      no_ack = 1'b1;
      for (int i = 0; i < N_RAND; i++) begin
         do_instr(pick_op($urandom_range(0, 3)), word_t'($urandom));
      end
      report_test("flag sequence", err0);

      // Flag low, irq high, flag bit kept clear for LDF
      err0 = errors;
      ack0 = ack_count;
      do_instr(CLI, '0);
      irq = 1'b1;
      for (int i = 0; i < N_MASK; i++) begin
         do_instr(pick_op($urandom_range(1, 3)),
                  word_t'($urandom) & ~(word_t'(1) << `CFT_FLAG_BIT));
      end
      check_count("acks while masked", ack_count - ack0, 0);
      report_test("masked irq", err0);

      err0   = errors;
      no_ack = 1'b0;
      ack0   = ack_count;
      tries  = 0;
      do_instr(STI, '0);
      while (ack_count == ack0 && tries < N_WAIT) begin
         do_instr(NOP, '0);
         tries++;
      end
      do_instr(NOP, '0);
      do_instr(NOP, '0);
      check_count("acks after STI", ack_count - ack0, 1);
      irq = 1'b0;
      report_test("interrupt entry", err0);

      // IDX mixed with NOP, random irq with the flag low
      err0     = errors;
      no_ack   = 1'b1;
      idx_sent = 0;
      do_instr(CLI, '0);
      strobe0 = strobe_count;
      for (int i = 0; i < N_IDX; i++) begin
         irq = 1'($urandom_range(0, 1));
         op  = ($urandom_range(0, 1) != 0) ? IDX : NOP;
         if (op == IDX) idx_sent++;
         do_instr(op, word_t'($urandom));
      end
      check_count("idx strobes", strobe_count - strobe0, idx_sent);
      report_test("index strobe", err0);

      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Run limit
   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk4);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== cft_int_top.sv ====
// Interrupt path top; opcode is sampled on instr_take, irq may be asynchronous
`timescale 1ns/1ps

module cft_int_top (
   input  logic                 clk4,
   input  logic                 rst,
   input  cft_ctl_pkg::opcode_t opcode,
   input  cft_bus_pkg::word_t   ibus,
   input  logic                 irq,
   output logic                 instr_take,
   output logic                 fi,
   output logic                 irqs,
   output logic                 irq_ack,
   output logic                 idx_strobe
);

   ////////////////////////////////////////
   // Sequencer to FSM link
   ////////////////////////////////////////

   int_if bus_if ();

   // Fetch, execute and interrupt entry
   micro_seq u_seq (
      .clk4       (clk4),
      .rst        (rst),
      .opcode     (opcode),
      .ibus       (ibus),
      .bus        (bus_if.seq),
      .instr_take (instr_take),
      .irq_ack    (irq_ack),
      .idx_strobe (idx_strobe)
   );

   // Flag, synchronizer and request register
   int_fsm u_fsm (
      .clk4 (clk4),
      .rst  (rst),
      .irq  (irq),
      .bus  (bus_if.fsm),
      .fi   (fi),
      .irqs (irqs)
   );

endmodule

// ==== micro_seq.sv ====
// Two-step sequencer; a pending request turns the next fetch slot into interrupt entry
`timescale 1ns/1ps

module micro_seq (
   input  logic                 clk4,
   input  logic                 rst,
   input  cft_ctl_pkg::opcode_t opcode,
   input  cft_bus_pkg::word_t   ibus,
   int_if.seq                   bus,
   output logic                 instr_take,
   output logic                 irq_ack,
   output logic                 idx_strobe
);

   import cft_ctl_pkg::*;
   import cft_bus_pkg::*;

   useq_state_t state_q;
   useq_state_t state_d;
   // Opcode latched at fetch
   opcode_t     op_q;
   action_t     action_d;
   logic        flag_we_d;
   word_t       flag_d_d;
   logic        fetch_ok;

   // Fetch only goes ahead with nothing pending
   assign fetch_ok = (state_q == S_FETCH) && !bus.irq_req;

   ////////////////////////////////////////
   // Sequence register
   ////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (rst) begin
         state_q <= S_FETCH;
      end else begin
         state_q <= state_d;
      end
   end

   // Opcode captured on the fetch strobe
   always_ff @(posedge clk4) begin
      if (fetch_ok) begin
         op_q <= opcode;
      end
   end

   // Next step
   always_comb begin
      state_d = state_q;
      case (state_q)
         S_FETCH:  state_d = bus.irq_req ? S_INTENT : S_EXEC;
         S_EXEC:   state_d = S_FETCH;
         S_INTENT: state_d = S_FETCH;
         default:  state_d = S_FETCH;
      endcase
   end

   ////////////////////////////////////////
   // Step outputs
   ////////////////////////////////////////

   always_comb begin
      action_d  = ACT_NONE;
      flag_we_d = 1'b0;
      flag_d_d  = '0;
      if (state_q == S_EXEC) begin
         case (op_q)
            STI: action_d = ACT_STI;
            CLI: action_d = ACT_CLI;
            IDX: action_d = ACT_IDX;
            LDF: begin
               // Flag load goes through the write strobe, not the action
               flag_we_d = 1'b1;
               flag_d_d  = ibus;
            end
            default: action_d = ACT_NONE;
         endcase
      end else if (state_q == S_INTENT) begin
         // Entry masks further interrupts
         action_d = ACT_CLI;
      end
   end

   assign bus.action    = action_d;
   assign bus.flag_we   = flag_we_d;
   assign bus.flag_d    = flag_d_d;
   assign bus.end_instr = (state_q == S_EXEC);

   assign instr_take = fetch_ok;
   assign irq_ack    = (state_q == S_INTENT);
   // Convenience strobe, decoded from the action field
   assign idx_strobe = (action_d == ACT_IDX);

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Entry CLI drops the request before the next fetch
   a_ack_drops_req: assert property (@(posedge clk4) disable iff (rst)
      irq_ack |=> !bus.irq_req);

   // Fetch and end of instruction are separate steps
   a_take_not_end: assert property (@(posedge clk4) disable iff (rst)
      !(instr_take && bus.end_instr));

endmodule

// ==== int_fsm.sv ====
// Interrupt flag and request logic; irq is asynchronous, requests only post at end of instruction
`timescale 1ns/1ps
`include "cft_consts.svh"

module int_fsm (
   input  logic clk4,
   input  logic rst,
   input  logic irq,
   // ibus15 is not needed because flag_d arrives through bus
   int_if.fsm   bus,
   output logic fi,
   output logic irqs
);

   import cft_ctl_pkg::*;
   import cft_bus_pkg::*;

   // Bit of the bus word that LDF loads
   localparam flag_pos_t FLAG_POS = flag_pos_t'(`CFT_FLAG_BIT);

   logic                        fi_q;
   logic [`CFT_SYNC_STAGES-1:0] irq_sync;
   logic                        irq_masked;
   logic                        irq_req_q;
   logic                        act_sti;
   logic                        act_cli;

   // Action decode
   assign act_sti = (bus.action == ACT_STI);
   assign act_cli = (bus.action == ACT_CLI);

   ////////////////////////////////////////
   // Interrupt flag
   ////////////////////////////////////////

   // Clear wins over set, set wins over load
   always_ff @(posedge clk4) begin
      if (rst || act_cli) begin
         fi_q <= 1'b0;
      end else if (act_sti) begin
         fi_q <= 1'b1;
      end else if (bus.flag_we) begin
         fi_q <= bus.flag_d[FLAG_POS];
      end
   end

   ////////////////////////////////////////
   // Request synchronizer
   ////////////////////////////////////////

   // Shift irq in at bit 0, oldest sample at the top
   always_ff @(posedge clk4) begin
      if (rst) begin
         irq_sync <= '0;
      end else begin
         irq_sync <= {irq_sync[`CFT_SYNC_STAGES-2:0], irq};
      end
   end

   // Held off while interrupts are disabled
   assign irq_masked = irq_sync[`CFT_SYNC_STAGES-1] & fi_q;

   // Request posts only on the edge that ends an instruction
   // CLI drops it, which also covers interrupt entry
   always_ff @(posedge clk4) begin
      if (rst || act_cli) begin
         irq_req_q <= 1'b0;
      end else if (bus.end_instr) begin
         irq_req_q <= irq_masked;
      end
   end

   assign bus.irq_req = irq_req_q;
   assign fi          = fi_q;
   // Bus and control copies of the request are one signal here
   assign irqs        = irq_req_q;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // A request can only be loaded while the flag was set
   a_req_needs_fi: assert property (@(posedge clk4) disable iff (rst)
      $rose(irq_req_q) |-> $past(fi_q));

   // Sequencer never clears and loads the flag in one step
   a_no_cli_with_load: assert property (@(posedge clk4) disable iff (rst)
      !(act_cli && bus.flag_we));

endmodule

// ==== int_if.sv ====
// Sequencer to interrupt FSM link; all signals are single-cycle levels with no back-pressure
`timescale 1ns/1ps

interface int_if;

   import cft_ctl_pkg::*;
   import cft_bus_pkg::*;

   // Microcode action for the current step
   action_t action;
   // Load fi from the bus word this cycle
   logic    flag_we;
   // Bus word sampled in EXEC of LDF
   word_t   flag_d;
   // Last step of an instruction
   logic    end_instr;
   // Pending interrupt toward the sequencer
   logic    irq_req;

   // Sequencer side
   modport seq (
      output action, flag_we, flag_d, end_instr,
      input  irq_req
   );

   // Interrupt FSM side
   modport fsm (
      input  action, flag_we, flag_d, end_instr,
      output irq_req
   );

endinterface

// ==== cft_bus_pkg.sv ====
// Bus side types; word width and flag position come from the consts header
`include "cft_consts.svh"

package cft_bus_pkg;

   ////////////////////////////////////////
   // Bus word
   ////////////////////////////////////////

   // One word on the internal bus
   typedef logic [`CFT_WORD_W-1:0] word_t;

   // Index of a single bit within a bus word
   // Wide enough to address any bit of word_t
   typedef logic [$clog2(`CFT_WORD_W)-1:0] flag_pos_t;

endpackage

// ==== cft_ctl_pkg.sv ====
// Control unit encodings; action values follow the microcode field, opcodes are a reduced set
`include "cft_consts.svh"

package cft_ctl_pkg;

   ////////////////////////////////////////
   // Instruction opcodes
   ////////////////////////////////////////

   // Only the opcodes that touch the interrupt path
   typedef enum logic [2:0] {
      NOP = 0,
      STI = 1,
      CLI = 2,
      LDF = 3,
      IDX = 4
   } opcode_t;

   ////////////////////////////////////////
   // Microcode action field
   ////////////////////////////////////////

   // Values match the action decoder outputs on the control board
   typedef enum logic [`CFT_ACT_W-1:0] {
      ACT_NONE = 0,
      ACT_STI  = 3,
      ACT_CLI  = 4,
      ACT_IDX  = 5
   } action_t;

   // Micro-sequencer steps
   typedef enum logic [1:0] {
      S_FETCH  = 0,
      S_EXEC   = 1,
      S_INTENT = 2
   } useq_state_t;

endpackage

// ==== cft_consts.svh ====
// Widths and bit positions for the interrupt path; CFT_FLAG_BIT must stay below CFT_WORD_W
`ifndef CFT_CONSTS_SVH
`define CFT_CONSTS_SVH

////////////////////////////////////////
// Bus side
////////////////////////////////////////

// Internal bus word width
`define CFT_WORD_W 16

// Bus bit copied into the interrupt flag by LDF
`define CFT_FLAG_BIT 15

////////////////////////////////////////
// Control side
////////////////////////////////////////

// Width of the microcode action field
`define CFT_ACT_W 4

// Flops between the irq pin and the masking logic
`define CFT_SYNC_STAGES 2

`endif
